// File: src/hist_pkg.sv
// Shared widths and packed types for the Bayer histogram.
// Every design file refers to these through hist_pkg:: scoped names.
// A bin address is {color, pixel value}, four colors of 256 bins each.

package hist_pkg;

    localparam int pix_w      = 8;     // pixel data width
    localparam int bin_addr_w = 10;    // 2 color bits + 8 value bits
    localparam int num_bins   = 1024;
    localparam int burst_len  = 256;   // bins per grant
    localparam int cnt_w      = 32;    // bin counter width
    localparam int coord_w    = 16;    // window coordinates

    // one pixel beat from the sensor
    typedef struct packed {
        logic             sof;   // start of frame pulse, in blanking
        logic             hact;  // line active level
        logic [pix_w-1:0] data;
    } pix_t;

    // window of interest, all fields in pixels/lines
    typedef struct packed {
        logic [coord_w-1:0] left;
        logic [coord_w-1:0] top;
        logic [coord_w-1:0] width_m1;
        logic [coord_w-1:0] height_m1;
    } win_cfg_t;

    typedef struct packed {
        logic [bin_addr_w-pix_w-1:0] color;  // bayer color, upper bits
        logic [pix_w-1:0]            value;
    } bin_addr_t;

    typedef logic [cnt_w-1:0] bin_cnt_t;

endpackage

// File: src/hist_bin_ram.sv
// Bin storage, one 32-bit count per bin, 1024 entries.
// Simple dual port: one synchronous read port and one write port.
// A read and a write to the same address in one cycle return the old data.

`timescale 1ns/1ps

module hist_bin_ram (
    input  logic                pclk,
    input  logic                rd_en_i,
    input  hist_pkg::bin_addr_t rd_addr_i,
    output hist_pkg::bin_cnt_t  rd_data_o,
    input  logic                we_i,
    input  hist_pkg::bin_addr_t wr_addr_i,
    input  hist_pkg::bin_cnt_t  wr_data_i
);

    hist_pkg::bin_cnt_t mem [hist_pkg::num_bins];

    always_ff @(posedge pclk) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];  // read first
        end
    end

endmodule

// File: src/hist_window.sv
// Window-of-interest tracker for the histogram.
// Counts lines (hact falling edges) and pixels from sof, keeps the Bayer
// color, and flags each pixel inside the window one cycle after its beat.
// sof is expected in blanking, before the first line of the frame.
// frame_done_o pulses once after the last window line ends.

`timescale 1ns/1ps

module hist_window (
    input  logic                pclk,
    input  logic                hist_rst_pclk,
    input  hist_pkg::pix_t      pix_i,
    input  hist_pkg::win_cfg_t  win_cfg_i,
    input  logic                win_set_i,
    input  logic                en_i,
    input  logic                arm_i,
    output logic                hit_o,
    output hist_pkg::bin_addr_t bin_o,
    output logic                frame_done_o
);

    hist_pkg::win_cfg_t           cfg_q;      // last written window
    hist_pkg::win_cfg_t           act_q;      // window used by this frame
    logic                         frame_act;
    logic                         hact_d;
    logic [1:0]                   bayer;
    logic [hist_pkg::coord_w-1:0] line_cnt;
    logic [hist_pkg::coord_w-1:0] pix_cnt;
    logic [hist_pkg::coord_w:0]   line_end;   // one extra bit, no wrap
    logic [hist_pkg::coord_w:0]   pix_end;
    logic                         hact_fall;
    logic                         in_v;
    logic                         in_h;
    logic                         last_line;
    logic                         arm_now;

    assign hact_fall = hact_d && !pix_i.hact;
    assign arm_now   = pix_i.sof && en_i && arm_i;
    assign line_end  = {1'b0, act_q.top} + {1'b0, act_q.height_m1};
    assign pix_end   = {1'b0, act_q.left} + {1'b0, act_q.width_m1};
    assign in_v      = (line_cnt >= act_q.top) && ({1'b0, line_cnt} <= line_end);
    assign in_h      = (pix_cnt >= act_q.left) && ({1'b0, pix_cnt} <= pix_end);
    assign last_line = frame_act && hact_fall && ({1'b0, line_cnt} == line_end);

    // position and color tracking, restarted by sof and hact
    always_ff @(posedge pclk) begin
        if (win_set_i) begin
            cfg_q <= win_cfg_i;
        end
        if (arm_now) begin
            act_q <= cfg_q;  // new window takes effect here
        end

        if (pix_i.sof) begin
            bayer <= '0;
        end else if (pix_i.hact) begin
            bayer <= {bayer[1], ~bayer[0]};
        end else begin
            bayer <= {bayer[1] ^ hact_fall, 1'b0};  // next line, other row color
        end

        if (pix_i.sof) begin
            line_cnt <= '0;
        end else if (hact_fall) begin
            line_cnt <= line_cnt + 1'b1;
        end

        if (!pix_i.hact) begin
            pix_cnt <= '0;
        end else begin
            pix_cnt <= pix_cnt + 1'b1;
        end

        bin_o.color <= bayer;
        bin_o.value <= pix_i.data;
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d       <= 1'b0;
            frame_act    <= 1'b0;
            hit_o        <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            hact_d <= pix_i.hact;
            if (!en_i) begin
                frame_act <= 1'b0;
            end else if (arm_now) begin
                frame_act <= 1'b1;
            end else if (last_line) begin
                frame_act <= 1'b0;
            end
            hit_o        <= frame_act && en_i && arm_i && pix_i.hact && in_v && in_h;
            frame_done_o <= last_line;
        end
    end

endmodule

// File: src/hist_accum.sv
// Histogram accumulator around the bin RAM.
// A hit reads its bin in the hit cycle and writes the count plus one in
// the next cycle. The previous write is forwarded when the next stage hits
// the same bin, so back-to-back equal pixels are not lost.
// Readout uses the same port pair: read the bin, then write zero back.

`timescale 1ns/1ps

module hist_accum (
    input  logic                pclk,
    input  logic                hist_rst_pclk,
    input  logic                hit_i,
    input  hist_pkg::bin_addr_t bin_i,
    input  logic                rd_en_i,
    input  hist_pkg::bin_addr_t rd_addr_i,
    output hist_pkg::bin_cnt_t  rd_data_o
);

    logic                ram_re;
    hist_pkg::bin_addr_t ram_raddr;
    hist_pkg::bin_cnt_t  ram_q;
    logic                ram_we;
    hist_pkg::bin_cnt_t  ram_wdata;
    logic                s1_hit;     // increment due this cycle
    logic                s1_clr;     // readout word due this cycle
    hist_pkg::bin_addr_t s1_addr;
    logic                last_vld;   // a write happened last cycle
    hist_pkg::bin_addr_t last_addr;
    hist_pkg::bin_cnt_t  last_data;
    logic                fwd;
    hist_pkg::bin_cnt_t  cur;

    // readout has the port during its burst, hits are held off by then
    assign ram_re    = hit_i || rd_en_i;
    assign ram_raddr = rd_en_i ? rd_addr_i : bin_i;

    assign fwd       = last_vld && (last_addr == s1_addr);
    assign cur       = fwd ? last_data : ram_q;  // ram missed last write
    assign ram_we    = s1_hit || s1_clr;
    assign ram_wdata = s1_clr ? '0 : cur + 1'b1;

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            s1_hit   <= 1'b0;
            s1_clr   <= 1'b0;
            last_vld <= 1'b0;
        end else begin
            s1_hit   <= hit_i;
            s1_clr   <= rd_en_i;
            last_vld <= ram_we;
        end
    end

    always_ff @(posedge pclk) begin
        s1_addr   <= ram_raddr;
        last_addr <= s1_addr;
        last_data <= ram_wdata;
        if (s1_clr) begin
            rd_data_o <= cur;
        end
    end

    hist_bin_ram u_ram (
        .pclk      (pclk),
        .rd_en_i   (ram_re),
        .rd_addr_i (ram_raddr),
        .rd_data_o (ram_q),
        .we_i      (ram_we),
        .wr_addr_i (s1_addr),
        .wr_data_i (ram_wdata)
    );

endmodule

// File: src/hist_readout.sv
// Histogram readout sequencer.
// After frame_done_i it requests the bus, and each accepted grant starts a
// burst of 256 bin reads in ascending address order, four bursts in all.
// Data words come out two cycles after their read, marked by hist_dv_o.
// xfer_done_o pulses after the read of the last bin.

`timescale 1ns/1ps

module hist_readout (
    input  logic                pclk,
    input  logic                hist_rst_pclk,
    input  logic                en_i,
    input  logic                frame_done_i,
    input  logic                hist_grant_i,
    output logic                hist_rq_o,
    output logic                rd_en_o,
    output hist_pkg::bin_addr_t rd_addr_o,
    input  hist_pkg::bin_cnt_t  rd_data_i,
    output hist_pkg::bin_cnt_t  hist_do_o,
    output logic                hist_dv_o,
    output logic                xfer_done_o
);

    localparam int burst_w = $clog2(hist_pkg::burst_len);

    logic                            pending;  // frame counted, not yet read out
    logic                            burst;
    logic [hist_pkg::bin_addr_w-1:0] rd_cnt;
    logic [1:0]                      dv_dly;   // ram plus output register
    logic                            grant_ok;
    logic                            burst_end;
    logic                            last_bin;

    assign grant_ok  = hist_grant_i && hist_rq_o;  // stray grants ignored
    assign burst_end = burst && (rd_cnt[burst_w-1:0] == burst_w'(hist_pkg::burst_len - 1));
    assign last_bin  = burst && (&rd_cnt);

    assign rd_en_o   = burst;
    assign rd_addr_o = hist_pkg::bin_addr_t'(rd_cnt);
    assign hist_do_o = rd_data_i;
    assign hist_dv_o = dv_dly[1];

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk || !en_i) begin
            pending     <= 1'b0;
            burst       <= 1'b0;
            hist_rq_o   <= 1'b0;
            rd_cnt      <= '0;
            dv_dly      <= '0;
            xfer_done_o <= 1'b0;
        end else begin
            if (frame_done_i) begin
                pending <= 1'b1;
            end else if (last_bin) begin
                pending <= 1'b0;
            end

            if (grant_ok) begin
                burst <= 1'b1;
            end else if (burst_end) begin
                burst <= 1'b0;
            end

            if (grant_ok) begin
                hist_rq_o <= 1'b0;
            end else if (pending && !burst) begin
                hist_rq_o <= 1'b1;  // also between bursts
            end

            if (burst) begin
                rd_cnt <= rd_cnt + 1'b1;  // wraps to 0 after the last bin
            end
            dv_dly      <= {dv_dly[0], burst};
            xfer_done_o <= last_bin;
        end
    end

endmodule

// File: src/hist_top.sv
// Per-color histogram of 8-bit Bayer pixels over a window of interest.
// hist_en_i enables at the next frame and disables once the running frame
// and its readout finish; hist_abort_i disables at once.
// While a readout is pending new frames are not counted, since every bin
// is cleared as it is read out.

`timescale 1ns/1ps

module hist_top (
    input  logic               pclk,
    input  logic               hist_rst_pclk,
    input  hist_pkg::pix_t     pix_i,
    input  hist_pkg::win_cfg_t win_cfg_i,
    input  logic               win_set_i,
    input  logic               hist_en_i,
    input  logic               hist_abort_i,
    input  logic               hist_grant_i,
    output logic               hist_rq_o,
    output hist_pkg::bin_cnt_t hist_do_o,
    output logic               hist_dv_o
);

    logic                en;
    logic                wait_readout;  // histogram holds an unread frame
    logic                frame_busy;    // window armed for the current frame
    logic                hit;
    hist_pkg::bin_addr_t bin;
    logic                frame_done;
    logic                rd_en;
    hist_pkg::bin_addr_t rd_addr;
    hist_pkg::bin_cnt_t  rd_data;
    logic                xfer_done;

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            en           <= 1'b0;
            wait_readout <= 1'b0;
            frame_busy   <= 1'b0;
        end else begin
            if (hist_abort_i) begin
                en <= 1'b0;
            end else if (hist_en_i) begin
                en <= 1'b1;
            end else if (!frame_busy && !wait_readout) begin
                en <= 1'b0;  // graceful off when idle
            end

            if (!en) begin
                wait_readout <= 1'b0;
            end else if (frame_done) begin
                wait_readout <= 1'b1;
            end else if (xfer_done) begin
                wait_readout <= 1'b0;
            end

            // same arming rule as the window
            if (!en) begin
                frame_busy <= 1'b0;
            end else if (pix_i.sof && !wait_readout) begin
                frame_busy <= 1'b1;
            end else if (frame_done) begin
                frame_busy <= 1'b0;
            end
        end
    end

    hist_window u_window (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .pix_i         (pix_i),
        .win_cfg_i     (win_cfg_i),
        .win_set_i     (win_set_i),
        .en_i          (en),
        .arm_i         (!wait_readout),
        .hit_o         (hit),
        .bin_o         (bin),
        .frame_done_o  (frame_done)
    );

    hist_accum u_accum (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .hit_i         (hit),
        .bin_i         (bin),
        .rd_en_i       (rd_en),
        .rd_addr_i     (rd_addr),
        .rd_data_o     (rd_data)
    );

    hist_readout u_readout (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .en_i          (en),
        .frame_done_i  (frame_done),
        .hist_grant_i  (hist_grant_i),
        .hist_rq_o     (hist_rq_o),
        .rd_en_o       (rd_en),
        .rd_addr_o     (rd_addr),
        .rd_data_i     (rd_data),
        .hist_do_o     (hist_do_o),
        .hist_dv_o     (hist_dv_o),
        .xfer_done_o   (xfer_done)
    );

endmodule

// File: testbench/hist_tb.sv
// Testbench for the Bayer histogram top level.
// Sends small random frames, keeps a reference histogram per color and
// checks each readout against it. The disabled and aborted cases are
// also covered, where no readout may be requested.

`timescale 1ns/1ps

module hist_tb #(
    parameter int seed_init = 61405
);

    localparam int lines     = 12;
    localparam int line_px   = 40;
    localparam int max_blank = 9;
    localparam int num_frame = 8;
    localparam int frame_cyc = lines * (line_px + max_blank) + 16;
    localparam int rd_cyc    = 4 * (hist_pkg::burst_len + 32);
    localparam int limit_ns  = num_frame * (frame_cyc + rd_cyc) * 2 * 10;
    localparam int bursts    = hist_pkg::num_bins / hist_pkg::burst_len;

    logic               pclk = 1'b0;
    logic               hist_rst_pclk;
    hist_pkg::pix_t     pix;
    hist_pkg::win_cfg_t win_cfg;
    logic               win_set;
    logic               hist_en;
    logic               hist_abort;
    logic               hist_grant;
    logic               hist_rq;
    hist_pkg::bin_cnt_t hist_do;
    logic               hist_dv;

    integer             seed = seed_init;
    hist_pkg::bin_cnt_t model [hist_pkg::num_bins];  // expected counts
    hist_pkg::bin_cnt_t rx    [hist_pkg::num_bins];  // words of the last readout
    int                 words    = 0;                // every hist_dv_o word seen
    int                 rx_base  = 0;
    int                 grants   = 0;                // grants of this readout
    int                 dv_errs  = 0;
    int                 errors   = 0;
    int                 t_errs   = 0;
    int                 t_run    = 0;
    int                 t_failed = 0;

    always #5 pclk = ~pclk;

    hist_top dut (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .pix_i         (pix),
        .win_cfg_i     (win_cfg),
        .win_set_i     (win_set),
        .hist_en_i     (hist_en),
        .hist_abort_i  (hist_abort),
        .hist_grant_i  (hist_grant),
        .hist_rq_o     (hist_rq),
        .hist_do_o     (hist_do),
        .hist_dv_o     (hist_dv)
    );

    // readout words in arrival order
    always @(negedge pclk) begin
        if (hist_dv) begin
            if (words - rx_base >= grants * hist_pkg::burst_len) begin
                $display("hist_dv_o went high without a grant at %0t", $time);
                dv_errs++;
            end else begin
                rx[10'(words - rx_base)] = hist_do;
            end
            words++;
        end
    end

    initial begin
        #(limit_ns);
        $display("Timeout after %0d ns, the readout handshake stalled", limit_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic int rnd(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic bit in_window(input int l, input int p);
        return l >= int'(win_cfg.top) && l <= int'(win_cfg.top) + int'(win_cfg.height_m1)
            && p >= int'(win_cfg.left) && p <= int'(win_cfg.left) + int'(win_cfg.width_m1);
    endfunction

    task automatic set_window(input int left, input int top, input int wm1, input int hm1);
        @(negedge pclk);
        win_cfg.left      = 16'(left);
        win_cfg.top       = 16'(top);
        win_cfg.width_m1  = 16'(wm1);
        win_cfg.height_m1 = 16'(hm1);
        win_set           = 1'b1;
        @(negedge pclk);
        win_set = 1'b0;
    endtask

    task automatic clear_model();
        for (int i = 0; i < hist_pkg::num_bins; i++) begin
            model[10'(i)] = '0;
        end
    endtask

    // one frame with sof in blanking and lines separated by random blanking
    task automatic send_frame(input bit count, input bit runs, input int abort_line);
        logic [hist_pkg::pix_w-1:0] val;
        int                         idx;
        val = 8'($random(seed));
        @(negedge pclk);
        pix     = '0;
        pix.sof = 1'b1;
        @(negedge pclk);
        pix.sof = 1'b0;
        repeat (4) @(negedge pclk);
        for (int l = 0; l < lines; l++) begin
            if (l == abort_line) begin
                hist_abort = 1'b1;  // enable dropped too so en stays off
                hist_en    = 1'b0;
            end
            for (int p = 0; p < line_px; p++) begin
                if (!runs || ($random(seed) & 7) == 0) begin
                    val = 8'($random(seed));  // runs of about 8 pixels
                end
                pix.hact = 1'b1;
                pix.data = val;
                idx = (l % 2) * 512 + (p % 2) * 256 + int'(val);  // color {row, column}
                if (count && in_window(l, p)) begin
                    model[10'(idx)]++;
                end
                @(negedge pclk);
                hist_abort = 1'b0;
            end
            pix.hact = 1'b0;
            pix.data = '0;
            repeat (2 + ($random(seed) & 7)) @(negedge pclk);
        end
    endtask

    // grant each request after a random delay and gather the 1024 words
    task automatic read_out(input bit compare, input int area);
        longint total;
        total = 0;
        @(posedge pclk);
        rx_base = words;
        grants  = 0;
        for (int b = 0; b < bursts; b++) begin
            @(negedge pclk);
            while (!hist_rq) @(negedge pclk);
            repeat ($random(seed) & 7) @(negedge pclk);
            hist_grant = 1'b1;
            @(posedge pclk);
            grants++;
            @(negedge pclk);
            hist_grant = 1'b0;
            if (hist_rq !== 1'b0) begin
                $display("Error: hist_rq_o is %h after a grant, expected 0", hist_rq);
                errors++;
            end
            while (words - rx_base < grants * hist_pkg::burst_len) @(posedge pclk);
        end
        repeat (20) @(negedge pclk);
        if (words - rx_base != hist_pkg::num_bins) begin
            $display("readout gave %0d words instead of %0d", words - rx_base,
                     hist_pkg::num_bins);
            errors++;
        end
        if (hist_rq) begin
            $display("Error: hist_rq_o is %h after the last burst, expected 0", hist_rq);
            errors++;
        end
        if (compare) begin
            for (int i = 0; i < hist_pkg::num_bins; i++) begin
                if (rx[10'(i)] !== model[10'(i)]) begin
                    $display("Error: hist_do_o bin %h is %h, expected %h",
                             10'(i), rx[10'(i)], model[10'(i)]);
                    errors++;
                end
                total += rx[10'(i)];
            end
            if (total != area) begin
                $display("Error: hist_do_o sum is %h, expected %h", total, area);
                errors++;
            end
        end
    endtask

    task automatic expect_idle(input int cycles);
        bit seen;
        seen = 1'b0;
        repeat (cycles) begin
            @(negedge pclk);
            if (hist_rq) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            $display("hist_rq_o rose although the histogram was disabled");
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        int now;
        now = errors + dv_errs;
        t_run++;
        if (now != t_errs) begin
            t_failed++;
            $display("test %s failed with %0d errors", name, now - t_errs);
        end else begin
            $display("test %s ok", name);
        end
        t_errs = now;
    endtask

    task automatic inner_frame(input string name);
        int left;
        int top;
        int wm1;
        int hm1;
        left = rnd(16);
        top  = rnd(6);
        wm1  = rnd(line_px - left);
        hm1  = rnd(lines - top);
        set_window(left, top, wm1, hm1);
        clear_model();
        send_frame(1'b1, 1'b0, -1);
        read_out(1'b1, (wm1 + 1) * (hm1 + 1));
        end_test(name);
    endtask

    initial begin
        hist_rst_pclk = 1'b1;
        pix           = '0;
        win_cfg       = '0;
        win_set       = 1'b0;
        hist_en       = 1'b0;
        hist_abort    = 1'b0;
        hist_grant    = 1'b0;
        repeat (4) @(posedge pclk);
        @(negedge pclk);
        hist_rst_pclk = 1'b0;

        if (hist_rq !== 1'b0) begin
            $display("Error: hist_rq_o after reset is %h, expected 0", hist_rq);
            errors++;
        end
        hist_grant = 1'b1;  // stray grant while nothing is requested
        @(negedge pclk);
        hist_grant = 1'b0;
        expect_idle(20);
        end_test("reset_idle");

        set_window(0, 0, line_px - 1, lines - 1);
        send_frame(1'b0, 1'b0, -1);
        expect_idle(40);
        end_test("disabled");

        // one discarded readout clears the unknown bins
        hist_en = 1'b1;
        send_frame(1'b0, 1'b0, -1);
        read_out(1'b0, 0);
        end_test("flush");

        clear_model();
        send_frame(1'b1, 1'b0, -1);
        read_out(1'b1, lines * line_px);
        end_test("full_window");

        inner_frame("inner_window");

        set_window(0, 0, line_px - 1, lines - 1);
        clear_model();
        send_frame(1'b1, 1'b1, -1);
        read_out(1'b1, lines * line_px);
        end_test("pixel_runs");

        inner_frame("clear_on_read");

        set_window(0, 0, line_px - 1, lines - 1);
        send_frame(1'b0, 1'b0, lines / 2);
        expect_idle(40);
        send_frame(1'b0, 1'b0, -1);
        expect_idle(40);
        end_test("abort");

        $display("%0d tests run, %0d failed, %0d errors", t_run, t_failed, errors + dv_errs);
        if (errors + dv_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: flist.f
src/hist_pkg.sv
src/hist_bin_ram.sv
src/hist_window.sv
src/hist_accum.sv
src/hist_readout.sv
src/hist_top.sv
testbench/hist_tb.sv

// File: Makefile
# Verilator build and run of the histogram testbench.
# Override on the command line, e.g. make run SEED=7

TOP       ?= hist_tb
FLIST     ?= flist.f
SEED      ?= 61405
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Gseed_init=$(SEED) --Mdir $(OBJ_DIR) -f $(FLIST)

# pass only if the simulation printed the pass message
run: compile
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
